/* rtl/fetch_pkg.sv */
// Fetch path shared definitions
`default_nettype none

package fetch_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // memory depth in words, addresses at or above MEM_WORDS*4 are out of range
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // read address channel payload
    typedef struct packed {
        logic [XLEN-1:0] addr;
    } rd_req_t;

    // read data channel payload
    typedef struct packed {
        logic [XLEN-1:0] data;
        logic            err;
    } rd_resp_t;

    // packet handed to the next stage
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic            err;
    } fetch_pkt_t;

    // preload write, enable travels separately
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } mem_write_t;

endpackage

`default_nettype wire

/* rtl/pc_gen.sv */
// Program counter unit
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect,
    input  logic [31:0] redirect_target,
    input  logic        fetch_done,
    output logic [31:0] pc,
    output logic        pc_change
);

    // low only in the first cycle out of reset
    logic started;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= fetch_pkg::RESET_PC;
            pc_change <= 1'b0;
            started   <= 1'b0;
        end else begin
            started <= 1'b1;
            // one pulse per pc update, plus the start pulse
            pc_change <= redirect | fetch_done | ~started;
            // redirect beats the sequential advance
            if (redirect) begin
                pc <= redirect_target;
            end else if (fetch_done) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ifu_fetch.sv */
// Instruction fetch master
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          pc,
    input  logic                 pc_change,
    output fetch_pkg::rd_req_t   req,
    output logic                 req_valid,
    input  logic                 req_ready,
    input  fetch_pkg::rd_resp_t  resp,
    input  logic                 resp_valid,
    output logic                 resp_ready,
    output logic                 fetch_done,
    output fetch_pkg::fetch_pkt_t pkt,
    output logic                 inst_valid
);

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } state_t;

    state_t      state;
    logic        new_pc;
    logic [31:0] req_pc;
    logic        addr_hs;
    logic        resp_hs;

    assign addr_hs = req_valid & req_ready;
    assign resp_hs = resp_valid & resp_ready;

    // request follows the live pc until the address is taken
    assign req.addr   = pc;
    assign req_valid  = (state == IDLE) & new_pc;
    assign resp_ready = (state == BUSY);

    // no advance when a newer pc is already waiting, so a redirect
    // target is never skipped by the old fetch finishing
    assign fetch_done = resp_hs & ~new_pc & ~pc_change;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (state == IDLE && addr_hs) begin
            state <= BUSY;
        end else if (state == BUSY && resp_hs) begin
            state <= IDLE;
        end
    end

    // pending flag, several changes collapse into one fetch of the latest pc
    always_ff @(posedge clk) begin
        if (rst) begin
            new_pc <= 1'b0;
        end else if (addr_hs) begin
            new_pc <= 1'b0;
        end else if (pc_change) begin
            new_pc <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= resp_hs;
        end
    end

    // tag keeps the pc the request went out with
    always_ff @(posedge clk) begin
        if (addr_hs) begin
            req_pc <= pc;
        end
        if (resp_hs) begin
            pkt.pc   <= req_pc;
            pkt.inst <= resp.data;
            pkt.err  <= resp.err;
        end
    end

endmodule

`default_nettype wire

/* rtl/read_arbiter.sv */
// Two-master read arbiter
`timescale 1ns/1ps
`default_nettype none

module read_arbiter (
    input  logic                clk,
    input  logic                rst,
    // fetch master
    input  fetch_pkg::rd_req_t  if_req,
    input  logic                if_req_valid,
    output logic                if_req_ready,
    output fetch_pkg::rd_resp_t if_resp,
    output logic                if_resp_valid,
    input  logic                if_resp_ready,
    // load/store master
    input  fetch_pkg::rd_req_t  ls_req,
    input  logic                ls_req_valid,
    output logic                ls_req_ready,
    output fetch_pkg::rd_resp_t ls_resp,
    output logic                ls_resp_valid,
    input  logic                ls_resp_ready,
    // memory slave
    output fetch_pkg::rd_req_t  mem_req,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    input  fetch_pkg::rd_resp_t mem_resp,
    input  logic                mem_resp_valid,
    output logic                mem_resp_ready
);

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_IF   = 2'd1,
        ARB_LS   = 2'd2
    } arb_state_t;

    arb_state_t state;
    logic       idle;
    logic       sel_ls;
    logic       addr_hs;
    logic       resp_hs;

    assign idle   = (state == ARB_IDLE);
    // load/store wins whenever it asks
    assign sel_ls = ls_req_valid;

    // address channel, open only while idle
    assign mem_req       = sel_ls ? ls_req : if_req;
    assign mem_req_valid = idle & (sel_ls ? ls_req_valid : if_req_valid);
    assign ls_req_ready  = idle & sel_ls & mem_req_ready;
    assign if_req_ready  = idle & ~sel_ls & mem_req_ready;

    // data channel, steered to the owner only
    assign if_resp        = mem_resp;
    assign ls_resp        = mem_resp;
    assign if_resp_valid  = (state == ARB_IF) & mem_resp_valid;
    assign ls_resp_valid  = (state == ARB_LS) & mem_resp_valid;
    assign mem_resp_ready = ((state == ARB_IF) & if_resp_ready) |
                            ((state == ARB_LS) & ls_resp_ready);

    assign addr_hs = mem_req_valid & mem_req_ready;
    assign resp_hs = mem_resp_valid & mem_resp_ready;

    // grant held from address handshake to response handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (addr_hs) begin
                        state <= sel_ls ? ARB_LS : ARB_IF;
                    end
                end
                ARB_IF, ARB_LS: begin
                    if (resp_hs) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/inst_mem.sv */
// Single-port word memory
`timescale 1ns/1ps
`default_nettype none

module inst_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::rd_req_t     req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output fetch_pkg::rd_resp_t    resp,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    input  logic                   load_en,
    input  fetch_pkg::mem_write_t  load
);

    logic [fetch_pkg::XLEN-1:0] mem [fetch_pkg::MEM_WORDS];

    logic                         accept;
    logic                         in_range;
    logic [fetch_pkg::MEM_AW-1:0] rd_idx;
    logic [fetch_pkg::MEM_AW-1:0] wr_idx;

    // one outstanding read at a time
    assign req_ready = ~resp_valid;
    assign accept    = req_valid & req_ready;

    assign in_range = req.addr < fetch_pkg::XLEN'(fetch_pkg::MEM_WORDS * 4);
    assign rd_idx   = req.addr[fetch_pkg::MEM_AW+1:2];
    assign wr_idx   = load.addr[fetch_pkg::MEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_valid && resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // read data held until the response is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            resp.data <= in_range ? mem[rd_idx] : '0;
            resp.err  <= ~in_range;
        end
    end

    // preload port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_idx] <= load.data;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
// Instruction fetch top level
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect,
    input  logic [31:0]           redirect_target,
    input  fetch_pkg::rd_req_t    ls_req,
    input  logic                  ls_req_valid,
    output logic                  ls_req_ready,
    output fetch_pkg::rd_resp_t   ls_resp,
    output logic                  ls_resp_valid,
    input  logic                  ls_resp_ready,
    input  logic                  load_en,
    input  fetch_pkg::mem_write_t load,
    output fetch_pkg::fetch_pkt_t pkt,
    output logic                  inst_valid
);

    logic [31:0]         pc;
    logic                pc_change;
    logic                fetch_done;

    // fetch unit to arbiter
    fetch_pkg::rd_req_t  if_req;
    logic                if_req_valid;
    logic                if_req_ready;
    fetch_pkg::rd_resp_t if_resp;
    logic                if_resp_valid;
    logic                if_resp_ready;

    // arbiter to memory
    fetch_pkg::rd_req_t  mem_req;
    logic                mem_req_valid;
    logic                mem_req_ready;
    fetch_pkg::rd_resp_t mem_resp;
    logic                mem_resp_valid;
    logic                mem_resp_ready;

    pc_gen u_pc_gen (
        .clk             (clk),
        .rst             (rst),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .fetch_done      (fetch_done),
        .pc              (pc),
        .pc_change       (pc_change)
    );

    ifu_fetch u_ifu_fetch (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .pc_change  (pc_change),
        .req        (if_req),
        .req_valid  (if_req_valid),
        .req_ready  (if_req_ready),
        .resp       (if_resp),
        .resp_valid (if_resp_valid),
        .resp_ready (if_resp_ready),
        .fetch_done (fetch_done),
        .pkt        (pkt),
        .inst_valid (inst_valid)
    );

    read_arbiter u_read_arbiter (
        .clk            (clk),
        .rst            (rst),
        .if_req         (if_req),
        .if_req_valid   (if_req_valid),
        .if_req_ready   (if_req_ready),
        .if_resp        (if_resp),
        .if_resp_valid  (if_resp_valid),
        .if_resp_ready  (if_resp_ready),
        .ls_req         (ls_req),
        .ls_req_valid   (ls_req_valid),
        .ls_req_ready   (ls_req_ready),
        .ls_resp        (ls_resp),
        .ls_resp_valid  (ls_resp_valid),
        .ls_resp_ready  (ls_resp_ready),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_resp       (mem_resp),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_ready (mem_resp_ready)
    );

    inst_mem u_inst_mem (
        .clk        (clk),
        .rst        (rst),
        .req        (mem_req),
        .req_valid  (mem_req_valid),
        .req_ready  (mem_req_ready),
        .resp       (mem_resp),
        .resp_valid (mem_resp_valid),
        .resp_ready (mem_resp_ready),
        .load_en    (load_en),
        .load       (load)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    input  logic hold,
    output logic clk,
    output logic rst
);

    logic [1:0] count;

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        count = 2'd0;
    end

    // 100 ns period
    always #50 clk = ~clk;

    // reset stays high while held, then two more cycles
    always @(posedge clk) begin
        if (hold) begin
            count <= 2'd0;
            rst   <= 1'b1;
        end else if (count != 2'd2) begin
            count <= count + 2'd1;
            rst   <= 1'b1;
        end else begin
            rst <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* bench/fetch_tb.sv */
// Instruction fetch testbench
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int TIMEOUT   = 200;
    localparam int LONG_WAIT = 1000;

    logic                  clk;
    logic                  rst;
    logic                  hold;
    logic                  redirect;
    logic [31:0]           redirect_target;
    fetch_pkg::rd_req_t    ls_req;
    logic                  ls_req_valid;
    logic                  ls_req_ready;
    fetch_pkg::rd_resp_t   ls_resp;
    logic                  ls_resp_valid;
    logic                  ls_resp_ready;
    logic                  load_en;
    fetch_pkg::mem_write_t load;
    fetch_pkg::fetch_pkt_t pkt;
    logic                  inst_valid;

    // reference memory image and golden records
    logic [31:0] exp_mem [fetch_pkg::MEM_WORDS];
    int          redir_cycle [$];
    logic [31:0] redir_tgt [$];
    logic [31:0] ls_addr [$];
    logic [31:0] ls_data [$];
    logic        ls_err [$];

    // main process side
    string       test_name = "reset";
    int          redir_id = 0;
    logic [31:0] redir_target = 32'd0;
    logic [31:0] rng = 32'd8;
    // monitor side
    int          cycle = 0;
    int          pkt_count = 0;
    int          matched_id = 0;
    logic        first_pkt = 1'b1;
    logic [31:0] last_pc = 32'd0;

    tb_clock u_clock (
        .hold (hold),
        .clk  (clk),
        .rst  (rst)
    );

    fetch_top DUT (
        .clk             (clk),
        .rst             (rst),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .ls_req          (ls_req),
        .ls_req_valid    (ls_req_valid),
        .ls_req_ready    (ls_req_ready),
        .ls_resp         (ls_resp),
        .ls_resp_valid   (ls_resp_valid),
        .ls_resp_ready   (ls_resp_ready),
        .load_en         (load_en),
        .load            (load),
        .pkt             (pkt),
        .inst_valid      (inst_valid)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
        stop_with_failure($sformatf("error %s %s: expected %h actual %h",
                                    test_name, what, exp, act));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // background pattern, golden words are laid over it
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h0001_0003) ^ 32'h5a5a_0000;
    endfunction

    // record kinds 0 memory word, 1 redirect, 2 load/store read
    task automatic read_golden();
        int          fd;
        int          code;
        int          kind;
        int          num;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("bench/fetch_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open bench/fetch_golden.txt");
        end
        code = $fscanf(fd, "%d", kind);
        while (code == 1) begin
            case (kind)
                0: begin
                    code = $fscanf(fd, "%h %h", a, d);
                    exp_mem[a[fetch_pkg::MEM_AW+1:2]] = d;
                end
                1: begin
                    code = $fscanf(fd, "%d %h", num, a);
                    redir_cycle.push_back(num);
                    redir_tgt.push_back(a);
                end
                default: begin
                    code = $fscanf(fd, "%h %h %h", a, d, e);
                    ls_addr.push_back(a);
                    ls_data.push_back(d);
                    ls_err.push_back(e[0]);
                end
            endcase
            code = $fscanf(fd, "%d", kind);
        end
        $fclose(fd);
        if (redir_tgt.size() == 0 || ls_addr.size() == 0) begin
            stop_with_failure("golden file holds no redirect or load records");
        end
    endtask

    task automatic check_packet(input fetch_pkg::fetch_pkt_t p);
        logic [31:0] exp_pc;
        logic [31:0] exp_inst;
        logic        in_range;
        exp_pc = first_pkt ? fetch_pkg::RESET_PC : last_pc + 32'd4;
        // an open redirect may replace the sequential pc
        if (redir_id != matched_id && p.pc == redir_target) begin
            exp_pc     = redir_target;
            matched_id = redir_id;
        end
        assert (p.pc == exp_pc) else value_error("pc", exp_pc, p.pc);
        in_range = p.pc < 32'(fetch_pkg::MEM_WORDS * 4);
        exp_inst = in_range ? exp_mem[p.pc[fetch_pkg::MEM_AW+1:2]] : 32'd0;
        assert (p.inst == exp_inst) else value_error("inst", exp_inst, p.inst);
        assert (p.err == !in_range) else value_error("err", 32'(!in_range), 32'(p.err));
        first_pkt = 1'b0;
        last_pc   = p.pc;
        pkt_count = pkt_count + 1;
    endtask

    // packet monitor and cycle count, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (inst_valid) begin
                check_packet(pkt);
            end
        end
    end

    task automatic wait_packets(input int n);
        int target;
        int waited;
        target = pkt_count + n;
        waited = 0;
        while (pkt_count < target) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_failure({"fetch packets stopped arriving during ", test_name});
            end
        end
    endtask

    task automatic do_redirect(input int at_cycle, input logic [31:0] target);
        int waited;
        waited = 0;
        while (cycle < at_cycle) begin
            @(posedge clk);
            waited++;
            if (waited > LONG_WAIT) begin
                stop_with_failure("cycle count never reached the redirect cycle");
            end
        end
        redir_target = target;
        redir_id     = redir_id + 1;
        redirect        <= 1'b1;
        redirect_target <= target;
        @(posedge clk);
        redirect <= 1'b0;
        waited = 0;
        while (matched_id != redir_id) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_failure({"no packet with the target pc during ", test_name});
            end
        end
    endtask

    task automatic ls_read(input logic [31:0] addr, input logic [31:0] exp_data,
                           input logic exp_err);
        int          waited;
        int          stall;
        logic [31:0] got_data;
        logic        got_err;
        ls_req_valid <= 1'b1;
        ls_req.addr  <= addr;
        waited = 0;
        // ready seen mid-cycle means the handshake is on the next edge
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_failure("load/store request was never accepted");
            end
        end while (!ls_req_ready);
        @(posedge clk);
        ls_req_valid <= 1'b0;
        rng   = xorshift(rng);
        stall = int'(rng % 32'd4);
        repeat (stall) @(posedge clk);
        ls_resp_ready <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_failure("load/store response never arrived");
            end
        end while (!ls_resp_valid);
        got_data = ls_resp.data;
        got_err  = ls_resp.err;
        @(posedge clk);
        ls_resp_ready <= 1'b0;
        assert (got_data == exp_data) else value_error("load data", exp_data, got_data);
        assert (got_err == exp_err) else value_error("load err", 32'(exp_err), 32'(got_err));
    endtask

    initial begin
        int waited;
        hold            = 1'b1;
        redirect        = 1'b0;
        redirect_target = 32'd0;
        ls_req          = '0;
        ls_req_valid    = 1'b0;
        ls_resp_ready   = 1'b0;
        load_en         = 1'b0;
        load            = '0;
        for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
            exp_mem[i] = fill_word(32'(i * 4));
        end
        read_golden();

        // whole image goes in while reset is held
        for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load.addr <= 32'(i * 4);
            load.data <= exp_mem[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        hold    <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_failure("reset was never released");
            end
        end while (rst);
        assert (!inst_valid) else value_error("inst_valid", 32'd0, 32'(inst_valid));
        assert (!ls_resp_valid) else value_error("ls_resp_valid", 32'd0, 32'(ls_resp_valid));
        @(posedge clk);

        test_name = "first packet";
        wait_packets(1);
        test_name = "sequential fetch";
        wait_packets(5);
        for (int i = 0; i < redir_tgt.size(); i++) begin
            test_name = $sformatf("redirect to %h", redir_tgt[i]);
            do_redirect(redir_cycle[i], redir_tgt[i]);
        end
        for (int i = 0; i < ls_addr.size(); i++) begin
            test_name = $sformatf("load read at %h", ls_addr[i]);
            ls_read(ls_addr[i], ls_data[i], ls_err[i]);
            wait_packets(1);
        end
        test_name = "fetch after loads";
        wait_packets(4);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/fetch_golden.txt */
0 00000000 00000013
0 00000004 00100093
0 00000008 00200113
0 0000000c 00308193
0 00000010 0000006f
0 00000100 40000237
0 00000104 004202b3
0 00000108 fe5ff06f
0 00000200 deadbeef
0 00000204 cafef00d
0 000003f0 12345678
0 000003f4 9abcdef0
0 000003fc 0badc0de
1 30 00000100
1 70 000003f0
1 110 00000800
1 150 00000200
1 190 00001000
1 230 00000008
2 00000100 40000237 0
2 000003fc 0badc0de 0
2 00000400 00000000 1
2 00000004 00100093 0
2 00000204 cafef00d 0
2 0000fffc 00000000 1

/* sim.f */
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/ifu_fetch.sv
rtl/read_arbiter.sv
rtl/inst_mem.sv
rtl/fetch_top.sv
bench/tb_clock.sv
bench/fetch_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fetch_tb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
